// File: Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_tag_store.sv
  - icache_data_store.sv
  - icache_ctrl.sv
  - icache_apb_refill.sv
  - icache_top.sv
  - target: test
    files:
      - tb_apb_rom.sv
      - tb_icache_top.sv

// File: build.f
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_apb_refill.sv
icache_top.sv
tb_apb_rom.sv
tb_icache_top.sv

// File: icache_apb_refill.sv
// apb read master fetching four words and assembling a cache line
`timescale 1ns/1ns

module icache_apb_refill (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                fill_start_i,
    input  logic [31:0]                         fill_addr_i,
    output logic                                fill_done_o,
    output logic [icache_pkg::ic_line_w-1:0]    fill_line_o,
    output icache_pkg::apb_req_t                apb_req_o,
    input  icache_pkg::apb_rsp_t                apb_rsp_i
);
    import icache_pkg::*;

    logic                   busy_q;
    logic                   penable_q;
    logic [ic_offset_w-1:0] beat_q;
    logic [31:4]            base_q;
    logic                   done_q;
    logic [ic_line_w-1:0]   line_q;
    logic                   last_beat;

    assign last_beat = (beat_q == ic_offset_w'(ic_words_per_line - 1));

    assign apb_req_o.psel    = busy_q;
    assign apb_req_o.penable = penable_q;
    assign apb_req_o.paddr   = {base_q, beat_q, 2'b00};

    assign fill_done_o = done_q;
    assign fill_line_o = line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            penable_q <= 1'b0;
            beat_q    <= '0;
            base_q    <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (fill_start_i) begin
                    busy_q <= 1'b1;
                    beat_q <= '0;
                    base_q <= fill_addr_i[31:4];
                end
            end else if (!penable_q) begin
                // setup phase lasts one cycle
                penable_q <= 1'b1;
            end else if (apb_rsp_i.pready) begin
                penable_q <= 1'b0;
                if (last_beat) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end
        end
    end

    // words enter at the top, so beat k ends up at bits 32k+31:32k
    always_ff @(posedge clk) begin
        if (busy_q && penable_q && apb_rsp_i.pready) begin
            line_q <= {apb_rsp_i.prdata, line_q[ic_line_w-1:32]};
        end
    end

endmodule

// File: icache_ctrl.sv
// lookup/refill FSM answering fetches and starting line refills
`timescale 1ns/1ns

module icache_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  icache_pkg::fetch_req_t              fetch_req_i,
    output icache_pkg::fetch_rsp_t              fetch_rsp_o,
    output logic [icache_pkg::ic_index_w-1:0]   index_o,
    output logic [icache_pkg::ic_tag_w-1:0]     tag_o,
    output logic [icache_pkg::ic_offset_w-1:0]  offset_o,
    input  logic                                hit_i,
    input  logic                                hit_way_i,
    input  logic                                victim_way_i,
    input  logic [31:0]                         rd_word_i,
    output logic                                hit_update_o,
    output logic                                fill_start_o,
    output logic [31:0]                         fill_addr_o,
    input  logic                                fill_done_i,
    input  logic [icache_pkg::ic_line_w-1:0]    fill_line_i,
    output icache_pkg::line_fill_t              fill_o,
    output logic                                fill_we_o
);
    import icache_pkg::*;

    ic_state_t state_q;
    ic_state_t state_d;
    logic      victim_q;

    // low two byte bits are dropped
    assign {tag_o, index_o, offset_o} = fetch_req_i.pc[31:2];

    assign fill_addr_o = {fetch_req_i.pc[31:4], 4'b0000};

    // fill_o also tells the tag store which way a hit touched
    assign fill_o.way   = (state_q == refill) ? victim_q : hit_way_i;
    assign fill_o.index = index_o;
    assign fill_o.tag   = tag_o;
    assign fill_o.line  = fill_line_i;

    always_comb begin
        state_d           = state_q;
        fetch_rsp_o.ready = 1'b0;
        fetch_rsp_o.inst  = rd_word_i;
        hit_update_o      = 1'b0;
        fill_start_o      = 1'b0;
        fill_we_o         = 1'b0;
        case (state_q)
            lookup: begin
                if (fetch_req_i.valid) begin
                    if (hit_i) begin
                        // hit answered in the same cycle
                        fetch_rsp_o.ready = 1'b1;
                        hit_update_o      = 1'b1;
                    end else begin
                        fill_start_o = 1'b1;
                        state_d      = refill;
                    end
                end
            end
            refill: begin
                // pc is held by the fetch stage, so index and tag still match
                if (fill_done_i) begin
                    fill_we_o = 1'b1;
                    state_d   = lookup;
                end
            end
            default: begin
                state_d = lookup;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= lookup;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // victim fixed at the miss
            if (fill_start_o) begin
                victim_q <= victim_way_i;
            end
        end
    end

endmodule

// File: icache_data_store.sv
// line storage for both ways with word select on read
`timescale 1ns/1ns

module icache_data_store (
    input  logic                                clk,
    input  logic [icache_pkg::ic_index_w-1:0]   rd_index_i,
    input  logic                                rd_way_i,
    input  logic [icache_pkg::ic_offset_w-1:0]  rd_offset_i,
    output logic [31:0]                         rd_word_o,
    input  icache_pkg::line_fill_t              fill_i,
    input  logic                                fill_we_i
);
    import icache_pkg::*;

    logic [ic_line_w-1:0] lines_q [ic_ways][ic_sets];
    logic [ic_line_w-1:0] rd_line;

    // whole line written at once by the refill
    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            lines_q[fill_i.way][fill_i.index] <= fill_i.line;
        end
    end

    assign rd_line = lines_q[rd_way_i][rd_index_i];

    // word k sits in bits 32k+31:32k
    always_comb begin
        rd_word_o = rd_line[32*rd_offset_i +: 32];
    end

endmodule

// File: icache_pkg.sv
// address fields, cache geometry, fetch/apb/fill structs and controller states
package icache_pkg;

    // pc split: | tag | index | word offset | byte |
    localparam int ic_tag_w    = 25;
    localparam int ic_index_w  = 3;
    localparam int ic_offset_w = 2;

    localparam int ic_sets           = 8;
    localparam int ic_ways           = 2;
    localparam int ic_line_w         = 128;
    localparam int ic_words_per_line = 4;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] inst;
    } fetch_rsp_t;

    // read-only apb3 master side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic [31:0] paddr;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
    } apb_rsp_t;

    // one line write into both stores
    typedef struct packed {
        logic                  way;
        logic [ic_index_w-1:0] index;
        logic [ic_tag_w-1:0]   tag;
        logic [ic_line_w-1:0]  line;
    } line_fill_t;

    typedef enum logic {
        lookup,
        refill
    } ic_state_t;

endpackage

// File: icache_tag_store.sv
// tag, valid and replacement arrays with hit compare and victim choice
`timescale 1ns/1ns

module icache_tag_store (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [icache_pkg::ic_index_w-1:0]   rd_index_i,
    input  logic [icache_pkg::ic_tag_w-1:0]     rd_tag_i,
    output logic                                hit_o,
    output logic                                hit_way_o,
    output logic                                victim_way_o,
    input  logic                                hit_update_i,
    input  icache_pkg::line_fill_t              fill_i,
    input  logic                                fill_we_i
);
    import icache_pkg::*;

    logic [ic_tag_w-1:0]              tag_q [ic_ways][ic_sets];
    logic [ic_ways-1:0][ic_sets-1:0]  valid_q;
    // per set, the way to fill next when both are valid
    logic [ic_sets-1:0]               repl_q;
    logic [ic_ways-1:0]               way_hit;

    for (genvar w = 0; w < ic_ways; w++) begin : g_cmp
        assign way_hit[w] = valid_q[w][rd_index_i] && (tag_q[w][rd_index_i] == rd_tag_i);
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // invalid ways first, then the replacement bit
    always_comb begin
        if (!valid_q[0][rd_index_i]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][rd_index_i]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = repl_q[rd_index_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            repl_q  <= '0;
        end else begin
            // hit or fill in way w points the set at the other way
            if (hit_update_i || fill_we_i) begin
                repl_q[fill_i.index] <= ~fill_i.way;
            end
            if (fill_we_i) begin
                valid_q[fill_i.way][fill_i.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            tag_q[fill_i.way][fill_i.index] <= fill_i.tag;
        end
    end

endmodule

// File: icache_top.sv
// instruction cache top with controller, tag and data stores, apb refill
`timescale 1ns/1ns

module icache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  icache_pkg::fetch_req_t  fetch_req_i,
    output icache_pkg::fetch_rsp_t  fetch_rsp_o,
    output icache_pkg::apb_req_t    apb_req_o,
    input  icache_pkg::apb_rsp_t    apb_rsp_i
);
    import icache_pkg::*;

    logic [ic_index_w-1:0]  index;
    logic [ic_tag_w-1:0]    tag;
    logic [ic_offset_w-1:0] offset;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic [31:0]            rd_word;
    logic                   hit_update;
    logic                   fill_start;
    logic [31:0]            fill_addr;
    logic                   fill_done;
    logic [ic_line_w-1:0]   fill_line;
    line_fill_t             fill;
    logic                   fill_we;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req_i  (fetch_req_i),
        .fetch_rsp_o  (fetch_rsp_o),
        .index_o      (index),
        .tag_o        (tag),
        .offset_o     (offset),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .victim_way_i (victim_way),
        .rd_word_i    (rd_word),
        .hit_update_o (hit_update),
        .fill_start_o (fill_start),
        .fill_addr_o  (fill_addr),
        .fill_done_i  (fill_done),
        .fill_line_i  (fill_line),
        .fill_o       (fill),
        .fill_we_o    (fill_we)
    );

    icache_tag_store u_tag_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_index_i   (index),
        .rd_tag_i     (tag),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way),
        .hit_update_i (hit_update),
        .fill_i       (fill),
        .fill_we_i    (fill_we)
    );

    icache_data_store u_data_store (
        .clk         (clk),
        .rd_index_i  (index),
        .rd_way_i    (hit_way),
        .rd_offset_i (offset),
        .rd_word_o   (rd_word),
        .fill_i      (fill),
        .fill_we_i   (fill_we)
    );

    icache_apb_refill u_apb_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill_start_i (fill_start),
        .fill_addr_i  (fill_addr),
        .fill_done_o  (fill_done),
        .fill_line_o  (fill_line),
        .apb_req_o    (apb_req_o),
        .apb_rsp_i    (apb_rsp_i)
    );

endmodule

// File: tb_apb_rom.sv
// apb rom model with random wait states and address-derived read data
`timescale 1ns/1ns

module tb_apb_rom (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [1:0]            wait_i,
    input  icache_pkg::apb_req_t  apb_req_i,
    output icache_pkg::apb_rsp_t  apb_rsp_o
);
    import icache_pkg::*;

    logic [1:0] wait_q;
    logic       access;

    // address xor constant, rotated left by a byte per word slot
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] x;
        logic [63:0] rot;
        x   = addr ^ 32'h3c5a_96e1;
        rot = {x, x} << {addr[3:2], 3'b000};
        return rot[63:32];
    endfunction

    assign access = apb_req_i.psel && apb_req_i.penable;

    // wait count is picked up in the setup phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= '0;
        end else if (apb_req_i.psel && !apb_req_i.penable) begin
            wait_q <= wait_i;
        end else if (access && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    assign apb_rsp_o.pready = access && (wait_q == 2'd0);
    assign apb_rsp_o.prdata = apb_rsp_o.pready ? rom_word(apb_req_i.paddr) : 32'h0;

endmodule

// File: tb_icache_top.sv
// testbench top: clock, reset, random fetches, cache model, check task, watchdog
`timescale 1ns/1ns

module tb_icache_top;
    import icache_pkg::*;

    localparam int clk_period       = 100;
    localparam int reset_cycles     = 16;
    localparam int n_random         = 400;
    localparam int n_directed       = 6;
    localparam int max_fetch_cycles = 40;
    localparam int watchdog_ns      =
        ((n_random + n_directed) * max_fetch_cycles + reset_cycles) * clk_period;

    logic        clk;
    logic        rst_n;
    logic [1:0]  rom_wait;
    integer      seed = 46;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] apb_addr_q [$];

    // reference tags, valid and replacement bits
    logic [ic_tag_w-1:0] model_tag   [ic_ways][ic_sets];
    logic                model_valid [ic_ways][ic_sets];
    logic                model_repl  [ic_sets];

    icache_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .apb_req_o   (apb_req),
        .apb_rsp_i   (apb_rsp)
    );

    tb_apb_rom u_rom (
        .clk       (clk),
        .rst_n     (rst_n),
        .wait_i    (rom_wait),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // wait states for the next beat, away from the fetch stimulus slot
    always @(posedge clk) begin
        #2;
        rom_wait = 2'($random(seed));
    end

    // completed apb transfers, in order
    always @(negedge clk) begin
        if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            apb_addr_q.push_back(apb_req.paddr);
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before all fetches completed");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] pc);
        logic [31:0] addr;
        logic [31:0] x;
        int          amt;
        addr = {pc[31:2], 2'b00};
        x    = addr ^ 32'h3c5a_96e1;
        amt  = 8 * addr[3:2];
        return (x << amt) | (x >> (32 - amt));
    endfunction

    // predicts hit or miss and updates the model like the cache would
    task automatic model_access(input logic [31:0] pc, output logic hit);
        logic [ic_index_w-1:0] idx;
        logic [ic_tag_w-1:0]   tag;
        logic                  way;
        idx = pc[6:4];
        tag = pc[31:7];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < ic_ways; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = (w == 1);
            end
        end
        if (!hit) begin
            if (!model_valid[0][idx]) begin
                way = 1'b0;
            end else if (!model_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = model_repl[idx];
            end
            model_valid[way][idx] = 1'b1;
            model_tag[way][idx]   = tag;
        end
        model_repl[idx] = ~way;
    endtask

    // called a little after a rising edge; returns one cycle later than ready
    task automatic run_fetch(input string name, input logic [31:0] pc, output logic missed);
        logic        exp_hit;
        int          cycles;
        logic [31:0] base;
        model_access(pc, exp_hit);
        base = {pc[31:4], 4'h0};
        apb_addr_q.delete();
        fetch_req.valid = 1'b1;
        fetch_req.pc    = pc;
        cycles          = 0;
        @(negedge clk);
        while (!fetch_rsp.ready) begin
            cycles++;
            @(negedge clk);
        end
        missed = (cycles != 0);
        compare_values({name, " inst"}, expected_word(pc), fetch_rsp.inst);
        compare_values({name, " miss"}, {31'b0, !exp_hit}, {31'b0, missed});
        if (missed) begin
            compare_values({name, " beats"}, 4, apb_addr_q.size());
            for (int k = 0; k < 4; k++) begin
                compare_values($sformatf("%s paddr %0d", name, k), base + 32'(4 * k),
                               apb_addr_q[k]);
            end
        end else begin
            compare_values({name, " beats"}, 0, apb_addr_q.size());
        end
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
    endtask

    initial begin
        logic        missed;
        logic [31:0] r_tag;
        logic [31:0] r_low;
        logic [31:0] pc;
        rst_n     = 1'b0;
        fetch_req = '0;
        rom_wait  = '0;
        for (int s = 0; s < ic_sets; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_repl[s]     = 1'b0;
        end

        // bus and fetch side quiet during reset and right after it
        repeat (reset_cycles) begin
            @(negedge clk);
            compare_values("reset psel", 0, apb_req.psel);
            compare_values("reset penable", 0, apb_req.penable);
            compare_values("reset ready", 0, fetch_rsp.ready);
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_values("post reset psel", 0, apb_req.psel);
        compare_values("post reset penable", 0, apb_req.penable);
        compare_values("post reset ready", 0, fetch_rsp.ready);
        @(posedge clk);
        #1;

        // lines A, B, C share set 5
        run_fetch("dir A first", 32'h0004_0054, missed);
        compare_values("dir A first miss", 1, missed);
        run_fetch("dir B first", 32'h0004_1058, missed);
        run_fetch("dir A again", 32'h0004_005c, missed);
        run_fetch("dir C", 32'h0004_2050, missed);
        run_fetch("dir B evicted", 32'h0004_1050, missed);
        compare_values("dir B evicted miss", 1, missed);
        run_fetch("dir A evicted", 32'h0004_0058, missed);
        compare_values("dir A evicted miss", 1, missed);

        // four tags over all sets, byte bits random too
        for (int i = 0; i < n_random; i++) begin
            r_tag = $random(seed);
            r_low = $random(seed);
            pc    = 32'h0004_0000 | ((r_tag & 32'h3) << 12) | (r_low & 32'h7f);
            run_fetch($sformatf("rand %0d", i), pc, missed);
            if ((r_low & 32'h300) == 32'h0) begin
                @(posedge clk);
                #1;
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule
